/* logic/dma_params.svh */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Byte address and beat widths
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 64

// Longest burst in beats
`define DMA_MAX_BURST 256

// On-chip memory depth in beats, indexed by byte address bits 12..3
`define DMA_MEM_WORDS 1024

`define DMA_FIFO_DEPTH 4

`endif

/* logic/dma_pkg.sv */
`include "dma_params.svh"

package dma_pkg;

   // Byte address, also used for byte lengths
   typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;

   // One beat on the read or write data channel
   typedef logic [`DMA_DATA_WIDTH-1:0] data_t;

   // Burst length in beats minus one
   typedef logic [$clog2(`DMA_MAX_BURST)-1:0] len_t;

   // Read request as held in the memory's request queue
   typedef struct packed {
      addr_t addr;
      len_t  len;
   } burst_t;

   // Read beat as held in the memory's beat queue
   typedef struct packed {
      data_t data;
      logic  last;
   } rbeat_t;

endpackage

/* logic/burst_fifo.sv */
`timescale 1ns/1ps

module burst_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  logic aclk,
   input  logic aresetn,
   input  logic push,
   input  T     push_data,
   input  logic pop,
   output T     pop_data,
   output logic full,
   output logic empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   T                 slots [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign empty = (count == '0);
   assign full  = (count == (PTR_W+1)'(DEPTH));

   // A pop on a full queue frees the slot for a push in the same cycle
   assign do_pop  = pop && !empty;
   assign do_push = push && (!full || do_pop);

   assign pop_data = slots[rd_ptr];

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (do_push) begin
         slots[wr_ptr] <= push_data;
      end
   end

endmodule

/* logic/data_mover.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module data_mover (
   input  logic            aclk,
   input  logic            aresetn,
   input  dma_pkg::addr_t  src_addr,
   input  dma_pkg::addr_t  dest_addr,
   input  dma_pkg::addr_t  length,
   input  logic            en,
   output logic            done,
   // Read request
   output dma_pkg::addr_t  ar_addr,
   output dma_pkg::len_t   ar_len,
   output logic            ar_valid,
   input  logic            ar_ready,
   // Read data
   input  dma_pkg::data_t  r_data,
   input  logic            r_last,
   input  logic            r_valid,
   output logic            r_ready,
   // Write request
   output dma_pkg::addr_t  aw_addr,
   output dma_pkg::len_t   aw_len,
   output logic            aw_valid,
   input  logic            aw_ready,
   // Write data and response
   output dma_pkg::data_t  w_data,
   output logic            w_last,
   output logic            w_valid,
   input  logic            w_ready,
   input  logic            b_valid,
   output logic            b_ready
);

   import dma_pkg::*;

   localparam int    ADDR_SHIFT  = $clog2(`DMA_DATA_WIDTH / 8);
   localparam addr_t BURST_BYTES = addr_t'(`DMA_MAX_BURST) << ADDR_SHIFT;
   localparam len_t  MAX_LEN     = len_t'(`DMA_MAX_BURST - 1);

   typedef enum logic [1:0] {
      S_IDLE,
      S_ADDR,
      S_WAIT,
      S_RESP
   } state_t;

   state_t state;

   // Job as latched from the host, then walked burst by burst
   addr_t src_next;
   addr_t dest_next;
   addr_t len_left;
   addr_t beats_left;
   logic  big_burst;

   logic  ar_taken;
   logic  aw_taken;
   logic  ar_hs;
   logic  aw_hs;

   // Read beats go straight out as write beats
   assign w_data  = r_data;
   assign w_last  = r_last;
   assign w_valid = r_valid;
   assign r_ready = w_ready;

   assign ar_hs = ar_valid && ar_ready;
   assign aw_hs = aw_valid && aw_ready;

   assign beats_left = len_left >> ADDR_SHIFT;
   assign big_burst  = (beats_left > addr_t'(`DMA_MAX_BURST));

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         state    <= S_IDLE;
         done     <= 1'b1;
         ar_valid <= 1'b0;
         aw_valid <= 1'b0;
         ar_taken <= 1'b0;
         aw_taken <= 1'b0;
         b_ready  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (en) begin
                  done  <= 1'b0;
                  state <= S_ADDR;
               end
            end
            S_ADDR: begin
               ar_valid <= 1'b1;
               aw_valid <= 1'b1;
               ar_taken <= 1'b0;
               aw_taken <= 1'b0;
               state    <= S_WAIT;
            end
            S_WAIT: begin
               if (ar_hs) begin
                  ar_valid <= 1'b0;
                  ar_taken <= 1'b1;
               end
               if (aw_hs) begin
                  aw_valid <= 1'b0;
                  aw_taken <= 1'b1;
               end
               // Both requests out, now wait for the write response
               if ((ar_taken || ar_hs) && (aw_taken || aw_hs)) begin
                  b_ready <= 1'b1;
                  state   <= S_RESP;
               end
            end
            S_RESP: begin
               if (b_valid) begin
                  b_ready <= 1'b0;
                  if (len_left == '0) begin
                     done  <= 1'b1;
                     state <= S_IDLE;
                  end else begin
                     state <= S_ADDR;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge aclk) begin
      if (state == S_IDLE && en) begin
         src_next  <= src_addr;
         dest_next <= dest_addr;
         len_left  <= length;
      end else if (state == S_ADDR) begin
         ar_addr <= {src_next[`DMA_ADDR_WIDTH-1:ADDR_SHIFT], {ADDR_SHIFT{1'b0}}};
         aw_addr <= {dest_next[`DMA_ADDR_WIDTH-1:ADDR_SHIFT], {ADDR_SHIFT{1'b0}}};
         if (big_burst) begin
            ar_len    <= MAX_LEN;
            aw_len    <= MAX_LEN;
            len_left  <= len_left - BURST_BYTES;
            src_next  <= src_next + BURST_BYTES;
            dest_next <= dest_next + BURST_BYTES;
         end else begin
            // Remainder fits in one burst
            ar_len   <= len_t'(beats_left - 1'b1);
            aw_len   <= len_t'(beats_left - 1'b1);
            len_left <= '0;
         end
      end
   end

endmodule

/* logic/axi_mem_slave.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module axi_mem_slave (
   input  logic                               aclk,
   input  logic                               aresetn,
   // Read request
   input  dma_pkg::addr_t                     ar_addr,
   input  dma_pkg::len_t                      ar_len,
   input  logic                               ar_valid,
   output logic                               ar_ready,
   // Read data
   output dma_pkg::data_t                     r_data,
   output logic                               r_last,
   output logic                               r_valid,
   input  logic                               r_ready,
   // Write request
   input  dma_pkg::addr_t                     aw_addr,
   input  dma_pkg::len_t                      aw_len,
   input  logic                               aw_valid,
   output logic                               aw_ready,
   // Write data and response
   input  dma_pkg::data_t                     w_data,
   input  logic                               w_last,
   input  logic                               w_valid,
   output logic                               w_ready,
   output logic                               b_valid,
   input  logic                               b_ready,
   // Host access, word indexed
   input  logic                               host_wr_en,
   input  logic [$clog2(`DMA_MEM_WORDS)-1:0]  host_addr,
   input  dma_pkg::data_t                     host_wr_data,
   output dma_pkg::data_t                     host_rd_data
);

   import dma_pkg::*;

   localparam int ADDR_SHIFT = $clog2(`DMA_DATA_WIDTH / 8);
   localparam int WORD_BITS  = $clog2(`DMA_MEM_WORDS);

   typedef logic [WORD_BITS-1:0] word_t;

   data_t  mem [`DMA_MEM_WORDS];

   // Read side
   burst_t req_in;
   burst_t req_head;
   logic   req_full;
   logic   req_empty;
   logic   req_pop;
   rbeat_t beat_in;
   rbeat_t beat_out;
   logic   beat_full;
   logic   beat_empty;
   logic   rd_active;
   word_t  rd_word;
   len_t   rd_left;
   logic   fetch;

   // Write side
   word_t  wr_word;
   len_t   wr_left;
   logic   aw_hs;
   logic   w_hs;
   logic   wr_end;

   assign ar_ready = !req_full;
   assign req_in   = '{addr: ar_addr, len: ar_len};

   burst_fifo #(
      .T     (burst_t),
      .DEPTH (`DMA_FIFO_DEPTH)
   ) u_req_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .push      (ar_valid && ar_ready),
      .push_data (req_in),
      .pop       (req_pop),
      .pop_data  (req_head),
      .full      (req_full),
      .empty     (req_empty)
   );

   // Next request is picked up once the current burst is fully fetched
   assign req_pop = !rd_active && !req_empty;
   assign fetch   = rd_active && !beat_full;
   assign beat_in = '{data: mem[rd_word], last: (rd_left == '0)};

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         rd_active <= 1'b0;
      end else if (req_pop) begin
         rd_active <= 1'b1;
      end else if (fetch && beat_in.last) begin
         rd_active <= 1'b0;
      end
   end

   always_ff @(posedge aclk) begin
      if (req_pop) begin
         rd_word <= req_head.addr[ADDR_SHIFT +: WORD_BITS];
         rd_left <= req_head.len;
      end else if (fetch) begin
         rd_word <= rd_word + 1'b1;
         rd_left <= rd_left - 1'b1;
      end
   end

   burst_fifo #(
      .T     (rbeat_t),
      .DEPTH (`DMA_FIFO_DEPTH)
   ) u_beat_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .push      (fetch),
      .push_data (beat_in),
      .pop       (r_valid && r_ready),
      .pop_data  (beat_out),
      .full      (beat_full),
      .empty     (beat_empty)
   );

   assign r_valid = !beat_empty;
   assign r_data  = beat_out.data;
   assign r_last  = beat_out.last;

   // One write burst at a time; w_ready doubles as the active flag
   assign aw_ready = !w_ready && !b_valid;
   assign aw_hs    = aw_valid && aw_ready;
   assign w_hs     = w_valid && w_ready;
   // Close on the last beat, or when the beat count runs out
   assign wr_end   = w_last || (wr_left == '0);

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         w_ready <= 1'b0;
         b_valid <= 1'b0;
      end else begin
         if (aw_hs) begin
            w_ready <= 1'b1;
         end else if (w_hs && wr_end) begin
            w_ready <= 1'b0;
            b_valid <= 1'b1;
         end
         if (b_valid && b_ready) begin
            b_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (aw_hs) begin
         wr_word <= aw_addr[ADDR_SHIFT +: WORD_BITS];
         wr_left <= aw_len;
      end else if (w_hs) begin
         wr_word <= wr_word + 1'b1;
         wr_left <= wr_left - 1'b1;
      end
   end

   // Host writes only happen while no copy runs
   always_ff @(posedge aclk) begin
      if (w_hs) begin
         mem[wr_word] <= w_data;
      end else if (host_wr_en) begin
         mem[host_addr] <= host_wr_data;
      end
      host_rd_data <= mem[host_addr];
   end

endmodule

/* logic/dma_copy_top.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_copy_top (
   input  logic                               aclk,
   input  logic                               aresetn,
   input  dma_pkg::addr_t                     src_addr,
   input  dma_pkg::addr_t                     dest_addr,
   input  dma_pkg::addr_t                     length,
   input  logic                               en,
   output logic                               done,
   input  logic                               host_wr_en,
   input  logic [$clog2(`DMA_MEM_WORDS)-1:0]  host_addr,
   input  dma_pkg::data_t                     host_wr_data,
   output dma_pkg::data_t                     host_rd_data
);

   import dma_pkg::*;

   // Mover to memory channels
   addr_t ar_addr;
   len_t  ar_len;
   logic  ar_valid;
   logic  ar_ready;
   data_t r_data;
   logic  r_last;
   logic  r_valid;
   logic  r_ready;
   addr_t aw_addr;
   len_t  aw_len;
   logic  aw_valid;
   logic  aw_ready;
   data_t w_data;
   logic  w_last;
   logic  w_valid;
   logic  w_ready;
   logic  b_valid;
   logic  b_ready;

   data_mover u_mover (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .src_addr  (src_addr),
      .dest_addr (dest_addr),
      .length    (length),
      .en        (en),
      .done      (done),
      .ar_addr   (ar_addr),
      .ar_len    (ar_len),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .r_data    (r_data),
      .r_last    (r_last),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .aw_addr   (aw_addr),
      .aw_len    (aw_len),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .w_data    (w_data),
      .w_last    (w_last),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .b_valid   (b_valid),
      .b_ready   (b_ready)
   );

   axi_mem_slave u_mem (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .ar_addr      (ar_addr),
      .ar_len       (ar_len),
      .ar_valid     (ar_valid),
      .ar_ready     (ar_ready),
      .r_data       (r_data),
      .r_last       (r_last),
      .r_valid      (r_valid),
      .r_ready      (r_ready),
      .aw_addr      (aw_addr),
      .aw_len       (aw_len),
      .aw_valid     (aw_valid),
      .aw_ready     (aw_ready),
      .w_data       (w_data),
      .w_last       (w_last),
      .w_valid      (w_valid),
      .w_ready      (w_ready),
      .b_valid      (b_valid),
      .b_ready      (b_ready),
      .host_wr_en   (host_wr_en),
      .host_addr    (host_addr),
      .host_wr_data (host_wr_data),
      .host_rd_data (host_rd_data)
   );

endmodule

/* tests/dma_copy_properties.sv */
`timescale 1ns/1ps

module dma_copy_properties (
   input  logic            aclk,
   input  logic            aresetn,
   input  logic            done,
   input  dma_pkg::addr_t  ar_addr,
   input  dma_pkg::len_t   ar_len,
   input  logic            ar_valid,
   input  logic            ar_ready,
   input  dma_pkg::addr_t  aw_addr,
   input  dma_pkg::len_t   aw_len,
   input  logic            aw_valid,
   input  logic            aw_ready,
   input  logic            b_ready
);

   // Read request holds with a stable payload until taken
   ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
      else $error("read request dropped or changed before it was taken");

   // Same rule on the write request
   aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len))
      else $error("write request dropped or changed before it was taken");

   // No response is awaited while the engine is idle
   resp_idle: assert property (@(posedge aclk) disable iff (!aresetn)
      !(b_ready && done))
      else $error("b_ready high while done is high");

   reset_done: assert property (@(posedge aclk)
      $rose(aresetn) |-> done)
      else $error("done low when leaving reset");

endmodule

/* tests/dma_copy_tb.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_copy_tb;

   import dma_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int MEM_WORDS  = `DMA_MEM_WORDS;
   localparam int BYTE_SHIFT = $clog2(`DMA_DATA_WIDTH / 8);
   localparam int SEED       = 41;
   localparam int RAND_JOBS  = 20;
   localparam int MAX_BEATS  = 400;
   // Every copied beat of the run, random jobs counted at their longest
   localparam int TOTAL_BEATS = 1 + 300 + RAND_JOBS * MAX_BEATS + 150 + 120 + 500;
   localparam int SWEEPS      = RAND_JOBS + 6;
   localparam int WATCHDOG_CYCLES = 40 * TOTAL_BEATS + SWEEPS * (MEM_WORDS + 8)
                                    + 2 * MEM_WORDS + 5000;

   typedef logic [$clog2(`DMA_MEM_WORDS)-1:0] word_t;

   logic  aclk;
   logic  aresetn;
   addr_t src_addr;
   addr_t dest_addr;
   addr_t length;
   logic  en;
   logic  done;
   logic  host_wr_en;
   word_t host_addr;
   data_t host_wr_data;
   data_t host_rd_data;

   // Shadow of the DUT memory
   data_t       ref_mem [MEM_WORDS];
   logic [31:0] lcg_state;

   word_t read_idx;
   logic  read_on;
   word_t chk_idx;
   logic  chk_valid;
   int    done_rises;

   dma_copy_top u_dma_copy_top (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .src_addr     (src_addr),
      .dest_addr    (dest_addr),
      .length       (length),
      .en           (en),
      .done         (done),
      .host_wr_en   (host_wr_en),
      .host_addr    (host_addr),
      .host_wr_data (host_wr_data),
      .host_rd_data (host_rd_data)
   );

   bind data_mover dma_copy_properties u_props (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .done     (done),
      .ar_addr  (ar_addr),
      .ar_len   (ar_len),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .aw_addr  (aw_addr),
      .aw_len   (aw_len),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .b_ready  (b_ready)
   );

   always #(CLK_PERIOD / 2) aclk = ~aclk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      return int'((lcg_next() >> 8) % 32'(n));
   endfunction

   function automatic addr_t to_bytes(input int words);
      return addr_t'(words) << BYTE_SHIFT;
   endfunction

   // Distinct value for every word index
   function automatic data_t pattern_word(input word_t idx);
      return {22'h2a5a5a, idx, 22'h15a5a5, ~idx};
   endfunction

   // Copy word by word in ascending order, word index wraps with the memory
   function automatic void apply_copy(input addr_t src, input addr_t dst, input addr_t len);
      word_t sw;
      word_t dw;
      sw = word_t'(src >> BYTE_SHIFT);
      dw = word_t'(dst >> BYTE_SHIFT);
      for (int k = 0; k < int'(len >> BYTE_SHIFT); k++) begin
         ref_mem[dw] = ref_mem[sw];
         sw = sw + 1'b1;
         dw = dw + 1'b1;
      end
   endfunction

   task automatic check_value(input string name, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         $display("Error: at %0t ns %s expected %h actual %h", $time, name, expected, actual);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // Host read data lags the address by one cycle
   always @(posedge aclk) begin
      chk_valid <= read_on;
      chk_idx   <= read_idx;
   end

   always @(negedge aclk) begin
      if (chk_valid) begin
         check_value($sformatf("host_rd_data[%0d]", chk_idx), ref_mem[chk_idx], host_rd_data);
      end
   end

   // Every finished job raises done exactly once
   always @(posedge done) begin
      done_rises = done_rises + 1;
   end

   task automatic next_cycle();
      @(posedge aclk);
      #1;
   endtask

   task automatic load_word(input word_t idx, input data_t value);
      host_wr_en   = 1'b1;
      host_addr    = idx;
      host_wr_data = value;
      ref_mem[idx] = value;
      next_cycle();
      host_wr_en = 1'b0;
   endtask

   task automatic sweep_memory();
      for (int i = 0; i < MEM_WORDS; i++) begin
         host_addr = word_t'(i);
         read_idx  = word_t'(i);
         read_on   = 1'b1;
         next_cycle();
      end
      read_on = 1'b0;
      next_cycle();
   endtask

   task automatic wait_done(input logic level);
      do begin
         next_cycle();
      end while (done !== level);
   endtask

   task automatic set_job(input int src_w, input int dst_w, input int beats);
      src_addr  = to_bytes(src_w);
      dest_addr = to_bytes(dst_w);
      length    = to_bytes(beats);
   endtask

   task automatic run_copy(input int src_w, input int dst_w, input int beats);
      int rises_at_start;
      set_job(src_w, dst_w, beats);
      en = 1'b1;
      next_cycle();
      check_value("done", data_t'(0), data_t'(done));
      rises_at_start = done_rises;
      en = 1'b0;
      wait_done(1'b1);
      apply_copy(src_addr, dest_addr, length);
      sweep_memory();
      // No early rise between bursts
      check_value("done_rises", data_t'(rises_at_start + 1), data_t'(done_rises));
   endtask

   initial begin
      int beats;
      int src_w;
      int dst_w;
      int gap;
      aclk         = 1'b0;
      aresetn      = 1'b1;
      src_addr     = '0;
      dest_addr    = '0;
      length       = '0;
      en           = 1'b0;
      host_wr_en   = 1'b0;
      host_addr    = '0;
      host_wr_data = '0;
      read_idx     = '0;
      read_on      = 1'b0;
      lcg_state    = 32'(SEED);
      #1;
      aresetn = 1'b0;
      repeat (8) @(posedge aclk);
      #1;
      aresetn = 1'b1;

      // Idle engine, memory reads back as loaded
      check_value("done", data_t'(1), data_t'(done));
      for (int i = 0; i < MEM_WORDS; i++) begin
         load_word(word_t'(i), {lcg_next(), lcg_next()});
      end
      sweep_memory();
      check_value("done", data_t'(1), data_t'(done));

      run_copy(5, 900, 1);
      // 256-beat burst then 44
      run_copy(40, 400, 300);

      // Destination starts past the source end with room left before it wraps back
      for (int j = 0; j < RAND_JOBS; j++) begin
         beats = 1 + rand_below(MAX_BEATS);
         src_w = rand_below(MEM_WORDS);
         gap   = rand_below(MEM_WORDS - 2 * beats + 1);
         dst_w = (src_w + beats + gap) % MEM_WORDS;
         run_copy(src_w, dst_w, beats);
      end

      // en stays high, second job copies the first one's destination onward
      set_job(10, 300, 150);
      en = 1'b1;
      next_cycle();
      check_value("done", data_t'(0), data_t'(done));
      set_job(300, 700, 120);
      wait_done(1'b1);
      next_cycle();
      check_value("done", data_t'(0), data_t'(done));
      en = 1'b0;
      wait_done(1'b1);
      apply_copy(to_bytes(10), to_bytes(300), to_bytes(150));
      apply_copy(to_bytes(300), to_bytes(700), to_bytes(120));
      sweep_memory();

      for (int i = 0; i < 500; i++) begin
         load_word(word_t'(i), pattern_word(word_t'(i)));
      end
      run_copy(0, 512, 500);

      $display("Test passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the copy did not finish in time");
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

endmodule

/* dma_copy.f */
+incdir+logic
logic/dma_pkg.sv
logic/burst_fifo.sv
logic/data_mover.sv
logic/axi_mem_slave.sv
logic/dma_copy_top.sv
tests/dma_copy_properties.sv
tests/dma_copy_tb.sv

/* Makefile */
TOP = dma_copy_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f dma_copy.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
